// File: all.f
+incdir+include
src/decoder_pkg.sv
src/grow_link.sv
src/processing_unit.sv
src/decoding_controller.sv
src/cluster_collector.sv
src/decoding_graph.sv
sim/decoding_graph_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the decoding graph testbench with Verilator and runs it.
# The run counts as failed if the fail message shows up in sim.log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    --top-module decoding_graph_tb \
    -f all.f \
    -o decoding_graph_sim > build.log 2>&1 \
    || { cat build.log; echo "Build failed, see build.log"; exit 1; }

./obj_dir/decoding_graph_sim > sim.log 2>&1
cat sim.log

grep -q "FAIL: see errors above" sim.log && exit 1
grep -q "PASS: all tests" sim.log && exit 0 || exit 1

// File: include/decoder_tb_tasks.svh
`ifndef DECODER_TB_TASKS_SVH
`define DECODER_TB_TASKS_SVH

task automatic check_value(input int actual, input int expected, input string what);
    if (actual != expected) begin
        $display("Fail at time %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at the first error");
    end
endtask

task automatic set_identity_roots();
    for (int i = 0; i < PU_COUNT; i++) begin
        expected_root[i] = i;
    end
endtask

// Bit r*CODE_DISTANCE+c of the frame is the defect at column c of round r.
task automatic send_frame(input logic [PU_COUNT-1:0] frame);
    for (int r = 0; r < ROUNDS; r++) begin
        @(posedge clk);
        while (upstream_credits() == 0) @(posedge clk);
        syndrome_valid <= 1'b1;
        syndrome_row <= frame[r*CODE_DISTANCE +: CODE_DISTANCE];
        beats_sent++;
    end
    @(posedge clk);
    syndrome_valid <= 1'b0;
endtask

// A max_gap of zero gives a credit every cycle until the frame is covered.
task automatic collect_records(input int max_gap);
    int received;
    int given;
    int gap;
    decoder_pkg::result_record_t rec;
    received = 0;
    given = 0;
    gap = 0;
    while (received < PU_COUNT) begin
        @(posedge clk);
        if (given < PU_COUNT && gap == 0) begin
            result_credit <= 1'b1;
            given++;
            credits_given++;
            gap = (max_gap == 0) ? 0 : int'($unsigned($random(seed)) % (max_gap + 1));
        end else begin
            result_credit <= 1'b0;
            if (gap > 0) gap--;
        end
        @(negedge clk);
        if (result_valid) begin
            rec = result;
            records_seen++;
            check_value(int'(records_seen <= credits_given), 1, "record within credit");
            check_value(int'(busy), 1, "busy while reporting");
            check_value(int'(rec.address), received, "record address");
            check_value(int'(rec.root), expected_root[received], "record root");
            received++;
        end
    end
    @(posedge clk);
    result_credit <= 1'b0;
    // Credit return runs on ROUNDS consecutive cycles right after the last record.
    repeat (ROUNDS + 2) @(negedge clk);
    frames_done++;
    check_value(credits_returned, ROUNDS * frames_done, "syndrome credits returned");
    check_value(int'(busy), 0, "busy after the last record");
endtask

task automatic test_empty_frame();
    set_identity_roots();
    send_frame(12'h000);
    collect_records(0);
endtask

task automatic test_adjacent_pair();
    set_identity_roots();
    expected_root[2] = 1;           // One grow fills the link between columns 1 and 2.
    send_frame(12'h006);
    collect_records(0);
endtask

// Two grows fill every link of unit 4, the vertical ones as well.
task automatic test_boundary_cluster();
    set_identity_roots();
    expected_root[4] = 0;
    expected_root[5] = 0;
    expected_root[8] = 0;
    send_frame(12'h010);
    collect_records(0);
endtask

task automatic test_vertical_pair();
    set_identity_roots();
    expected_root[6] = 2;
    send_frame(12'h044);
    collect_records(0);
endtask

task automatic test_credit_gaps();
    set_identity_roots();
    expected_root[10] = 9;
    send_frame(12'h600);
    collect_records(4);
    set_identity_roots();
    expected_root[7] = 3;           // Their east boundary links stay half grown.
    send_frame(12'h088);
    collect_records(3);
endtask

`endif

// File: sim/decoding_graph_tb.sv
`timescale 1ns/10ps
`default_nettype none

module decoding_graph_tb;

    localparam int CODE_DISTANCE = 4;
    localparam int ROUNDS = 3;
    localparam int H_WEIGHT = 2;
    localparam int V_WEIGHT = 2;
    localparam int PU_COUNT = CODE_DISTANCE * ROUNDS;
    localparam int RESET_CYCLES = 16;
    // Six frames of well under 200 cycles each, plus reset, with a wide margin.
    localparam int TIMEOUT_CYCLES = 2000;

    logic                         clk = 1'b0;
    logic                         reset = 1'b1;
    logic                         syndrome_valid = 1'b0;
    logic [CODE_DISTANCE-1:0]     syndrome_row = '0;
    logic                         result_credit = 1'b0;
    logic                         syndrome_credit;
    logic                         result_valid;
    decoder_pkg::result_record_t  result;
    logic                         busy;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bookkeeping
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    integer seed;
    int     cycle_count = 0;
    int     credits_returned = 0;   // Pulses seen on syndrome_credit.
    int     beats_sent = 0;
    int     credits_given = 0;      // Result credits over the whole run.
    int     records_seen = 0;
    int     frames_done = 0;
    int     expected_root [PU_COUNT];

    decoding_graph #(
        .CODE_DISTANCE(CODE_DISTANCE),
        .ROUNDS(ROUNDS),
        .H_WEIGHT(H_WEIGHT),
        .V_WEIGHT(V_WEIGHT)
    ) decoding_graph_inst (
        .clk(clk),
        .reset(reset),
        .syndrome_valid(syndrome_valid),
        .syndrome_row(syndrome_row),
        .result_credit(result_credit),
        .syndrome_credit(syndrome_credit),
        .result_valid(result_valid),
        .result(result),
        .busy(busy)
    );

    always #10 clk = ~clk;

    // Each high cycle hands one beat of credit back upstream.
    always @(negedge clk) begin
        if (!reset && syndrome_credit) begin
            credits_returned <= credits_returned + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the decoder did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $fatal(1, "run stopped");
        end
    end

    // Upstream starts a frame with ROUNDS credits.
    function automatic int upstream_credits();
        return ROUNDS + credits_returned - beats_sent;
    endfunction

    `include "decoder_tb_tasks.svh"

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        seed = 32'h7e58ff1d;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value(int'(busy), 0, "busy after reset");
        check_value(int'(syndrome_credit), 0, "syndrome_credit after reset");
        check_value(int'(result_valid), 0, "result_valid after reset");

        test_empty_frame();
        test_adjacent_pair();
        test_boundary_cluster();
        test_vertical_pair();
        test_credit_gaps();

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/decoding_graph.sv
`timescale 1ns/10ps
`default_nettype none

module decoding_graph #(
    parameter int CODE_DISTANCE = 4,
    parameter int ROUNDS = 3,
    parameter int H_WEIGHT = 2,
    parameter int V_WEIGHT = 2
) (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         syndrome_valid,
    input  wire  [CODE_DISTANCE-1:0]    syndrome_row,
    input  wire                         result_credit,
    output logic                        syndrome_credit,
    output logic                        result_valid,
    output decoder_pkg::result_record_t result,
    output logic                        busy
);

    localparam int PU_COUNT = CODE_DISTANCE * ROUNDS;

    wire decoder_pkg::stage_t               stage;
    wire [PU_COUNT-1:0]                     defects;
    wire [PU_COUNT-1:0]                     root_changed;
    wire [PU_COUNT-1:0]                     boundary_touch;
    wire [PU_COUNT-1:0]                     odd_flags;
    wire                                    any_odd;
    wire                                    report_done;
    wire decoder_pkg::addr_t [PU_COUNT-1:0] roots;

    // What each unit hears from its four links.
    wire decoder_pkg::neighbor_t west_in  [PU_COUNT];
    wire decoder_pkg::neighbor_t east_in  [PU_COUNT];
    wire decoder_pkg::neighbor_t below_in [PU_COUNT];
    wire decoder_pkg::neighbor_t above_in [PU_COUNT];

    decoding_controller #(
        .CODE_DISTANCE(CODE_DISTANCE),
        .ROUNDS(ROUNDS)
    ) controller_inst (
        .clk(clk),
        .reset(reset),
        .syndrome_valid(syndrome_valid),
        .syndrome_row(syndrome_row),
        .root_changed(root_changed),
        .any_odd(any_odd),
        .report_done(report_done),
        .syndrome_credit(syndrome_credit),
        .stage(stage),
        .defects(defects),
        .busy(busy)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Unit grid
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar r = 0; r < ROUNDS; r++) begin : round_g
        for (genvar c = 0; c < CODE_DISTANCE; c++) begin : col_g
            localparam int IDX = r * CODE_DISTANCE + c;

            // No round before the first or after the last, so these never grow.
            if (r == 0) begin : bottom_g
                assign below_in[IDX] = '{fully_grown: 1'b0, root: decoder_pkg::addr_t'(IDX)};
            end
            if (r == ROUNDS - 1) begin : top_g
                assign above_in[IDX] = '{fully_grown: 1'b0, root: decoder_pkg::addr_t'(IDX)};
            end

            processing_unit #(
                .CODE_DISTANCE(CODE_DISTANCE),
                .ADDRESS(IDX)
            ) unit_inst (
                .clk(clk),
                .reset(reset),
                .stage(stage),
                .west(west_in[IDX]),
                .east(east_in[IDX]),
                .below(below_in[IDX]),
                .above(above_in[IDX]),
                .root(roots[IDX]),
                .root_changed(root_changed[IDX]),
                .boundary_touch(boundary_touch[IDX])
            );
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Links
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Link c of a row sits west of column c; links 0 and CODE_DISTANCE are boundaries.
    for (genvar r = 0; r < ROUNDS; r++) begin : h_round_g
        for (genvar c = 0; c <= CODE_DISTANCE; c++) begin : h_col_g
            if (c == 0 || c == CODE_DISTANCE) begin : edge_g
                localparam int A = r * CODE_DISTANCE + ((c == 0) ? 0 : CODE_DISTANCE - 1);
                wire decoder_pkg::neighbor_t to_unit;

                grow_link #(
                    .WEIGHT(H_WEIGHT),
                    .IS_BOUNDARY(1'b1)
                ) link_inst (
                    .clk(clk),
                    .reset(reset),
                    .stage(stage),
                    .a_root(roots[A]),
                    .b_root('0),
                    .a_odd(odd_flags[A]),
                    .b_odd(1'b0),
                    .to_a(to_unit),
                    .to_b()
                );

                if (c == 0) begin : west_g
                    assign west_in[A] = to_unit;
                end else begin : east_g
                    assign east_in[A] = to_unit;
                end
            end else begin : inner_g
                localparam int A = r * CODE_DISTANCE + c - 1;
                localparam int B = A + 1;

                grow_link #(
                    .WEIGHT(H_WEIGHT),
                    .IS_BOUNDARY(1'b0)
                ) link_inst (
                    .clk(clk),
                    .reset(reset),
                    .stage(stage),
                    .a_root(roots[A]),
                    .b_root(roots[B]),
                    .a_odd(odd_flags[A]),
                    .b_odd(odd_flags[B]),
                    .to_a(east_in[A]),
                    .to_b(west_in[B])
                );
            end
        end
    end

    // Links between consecutive measurement rounds.
    for (genvar r = 1; r < ROUNDS; r++) begin : v_round_g
        for (genvar c = 0; c < CODE_DISTANCE; c++) begin : v_col_g
            localparam int A = (r - 1) * CODE_DISTANCE + c;
            localparam int B = A + CODE_DISTANCE;

            grow_link #(
                .WEIGHT(V_WEIGHT),
                .IS_BOUNDARY(1'b0)
            ) link_inst (
                .clk(clk),
                .reset(reset),
                .stage(stage),
                .a_root(roots[A]),
                .b_root(roots[B]),
                .a_odd(odd_flags[A]),
                .b_odd(odd_flags[B]),
                .to_a(above_in[A]),
                .to_b(below_in[B])
            );
        end
    end

    cluster_collector #(
        .CODE_DISTANCE(CODE_DISTANCE),
        .ROUNDS(ROUNDS)
    ) collector_inst (
        .clk(clk),
        .reset(reset),
        .stage(stage),
        .defects(defects),
        .roots(roots),
        .boundary_touch(boundary_touch),
        .result_credit(result_credit),
        .odd_flags(odd_flags),
        .any_odd(any_odd),
        .result_valid(result_valid),
        .result(result),
        .report_done(report_done)
    );

endmodule

`default_nettype wire

// File: src/cluster_collector.sv
`timescale 1ns/10ps
`default_nettype none

module cluster_collector #(
    parameter int CODE_DISTANCE = 4,
    parameter int ROUNDS = 3,
    localparam int PU_COUNT = CODE_DISTANCE * ROUNDS,
    localparam int CREDIT_WIDTH = $clog2(PU_COUNT + 1) + 1
) (
    input  wire                                     clk,
    input  wire                                     reset,
    input  wire decoder_pkg::stage_t                stage,
    input  wire [PU_COUNT-1:0]                      defects,
    input  wire decoder_pkg::addr_t [PU_COUNT-1:0]  roots,
    input  wire [PU_COUNT-1:0]                      boundary_touch,
    input  wire                                     result_credit,
    output logic [PU_COUNT-1:0]                     odd_flags,
    output logic                                    any_odd,
    output logic                                    result_valid,
    output decoder_pkg::result_record_t             result,
    output logic                                    report_done
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Cluster parity
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Both vectors are indexed by root address, not by unit.
    logic [PU_COUNT-1:0] root_parity;
    logic [PU_COUNT-1:0] root_touch;

    always_comb begin
        root_parity = '0;
        root_touch  = '0;
        for (int i = 0; i < PU_COUNT; i++) begin
            root_parity[roots[i]] = root_parity[roots[i]] ^ defects[i];
            root_touch[roots[i]]  = root_touch[roots[i]] | boundary_touch[i];
        end
    end

    // A cluster that reaches a boundary can always be matched there.
    always_comb begin
        for (int i = 0; i < PU_COUNT; i++) begin
            odd_flags[i] = root_parity[roots[i]] & ~root_touch[roots[i]];
        end
    end

    assign any_odd = |odd_flags;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Result stream
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic [CREDIT_WIDTH-1:0] credit_count;
    decoder_pkg::addr_t      record_index;
    logic                    send;

    assign send = (stage == decoder_pkg::stage_reporting) && (credit_count != '0);

    assign result_valid = send;
    assign result = '{address: record_index, root: roots[record_index]};
    assign report_done = send && (record_index == decoder_pkg::addr_t'(PU_COUNT - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            credit_count <= '0;
            record_index <= '0;
        end else begin
            // Credits may arrive in any stage and are kept for the next report.
            case ({result_credit, send})
                2'b10:   credit_count <= credit_count + 1'b1;
                2'b01:   credit_count <= credit_count - 1'b1;
                default: credit_count <= credit_count;
            endcase

            if (send) begin
                record_index <= report_done ? '0 : record_index + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/decoding_controller.sv
`timescale 1ns/10ps
`default_nettype none

module decoding_controller #(
    parameter int CODE_DISTANCE = 4,
    parameter int ROUNDS = 3,
    localparam int PU_COUNT = CODE_DISTANCE * ROUNDS,
    localparam int COUNT_WIDTH = $clog2(ROUNDS + 1)
) (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         syndrome_valid,
    input  wire  [CODE_DISTANCE-1:0]    syndrome_row,
    input  wire  [PU_COUNT-1:0]         root_changed,
    input  wire                         any_odd,
    input  wire                         report_done,
    output logic                        syndrome_credit,
    output decoder_pkg::stage_t         stage,
    output logic [PU_COUNT-1:0]         defects,
    output logic                        busy
);

    logic [COUNT_WIDTH-1:0] round_count;
    logic [COUNT_WIDTH-1:0] credit_count;   // Credits still to hand back upstream.
    logic [PU_COUNT-1:0]    frame;
    logic                   accept;
    logic                   last_row;

    // Upstream only sends while it holds credit, so a beat is never refused here.
    assign accept = syndrome_valid &&
                    (stage == decoder_pkg::stage_idle || stage == decoder_pkg::stage_loading);
    assign last_row = (round_count == COUNT_WIDTH'(ROUNDS - 1));

    assign defects = frame;
    assign syndrome_credit = (credit_count != '0);

    // Round r lands at addresses r*CODE_DISTANCE and up.
    always_ff @(posedge clk) begin
        if (accept) begin
            frame[round_count*CODE_DISTANCE +: CODE_DISTANCE] <= syndrome_row;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage sequencing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            stage        <= decoder_pkg::stage_idle;
            round_count  <= '0;
            credit_count <= '0;
            busy         <= 1'b0;
        end else begin
            if (credit_count != '0) begin
                credit_count <= credit_count - 1'b1;
            end

            case (stage)
                decoder_pkg::stage_idle, decoder_pkg::stage_loading: begin
                    if (accept) begin
                        busy <= 1'b1;
                        if (last_row) begin
                            round_count <= '0;
                            stage       <= decoder_pkg::stage_merging;
                        end else begin
                            round_count <= round_count + 1'b1;
                            stage       <= decoder_pkg::stage_loading;
                        end
                    end
                end
                decoder_pkg::stage_merging: begin
                    if (!(|root_changed)) begin   // Roots have settled.
                        stage <= decoder_pkg::stage_checking;
                    end
                end
                decoder_pkg::stage_checking: begin
                    stage <= any_odd ? decoder_pkg::stage_growing : decoder_pkg::stage_reporting;
                end
                decoder_pkg::stage_growing: begin
                    stage <= decoder_pkg::stage_merging;
                end
                decoder_pkg::stage_reporting: begin
                    if (report_done) begin
                        stage        <= decoder_pkg::stage_idle;
                        busy         <= 1'b0;
                        credit_count <= COUNT_WIDTH'(ROUNDS);  // One credit per round.
                    end
                end
                default: begin
                    stage <= decoder_pkg::stage_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/processing_unit.sv
`timescale 1ns/10ps
`default_nettype none

module processing_unit #(
    parameter int CODE_DISTANCE = 4,
    parameter int ADDRESS = 0
) (
    input  wire                         clk,
    input  wire                         reset,
    input  wire decoder_pkg::stage_t    stage,
    input  wire decoder_pkg::neighbor_t west,
    input  wire decoder_pkg::neighbor_t east,
    input  wire decoder_pkg::neighbor_t below,
    input  wire decoder_pkg::neighbor_t above,
    output decoder_pkg::addr_t          root,
    output logic                        root_changed,
    output logic                        boundary_touch
);

    localparam int COLUMN = ADDRESS % CODE_DISTANCE;
    localparam decoder_pkg::addr_t SELF = decoder_pkg::addr_t'(ADDRESS);

    decoder_pkg::addr_t min_root;

    // Smallest root seen over the fully grown links.
    always_comb begin
        min_root = root;
        if (west.fully_grown && (west.root < min_root)) begin
            min_root = west.root;
        end
        if (east.fully_grown && (east.root < min_root)) begin
            min_root = east.root;
        end
        if (below.fully_grown && (below.root < min_root)) begin
            min_root = below.root;
        end
        if (above.fully_grown && (above.root < min_root)) begin
            min_root = above.root;
        end
    end

    // Every unit starts a frame as its own root.
    always_ff @(posedge clk) begin
        if (reset || stage == decoder_pkg::stage_idle || stage == decoder_pkg::stage_loading) begin
            root <= SELF;
        end else if (stage == decoder_pkg::stage_merging) begin
            root <= min_root;
        end
    end

    assign root_changed = (stage == decoder_pkg::stage_merging) && (min_root != root);

    // Only the row ends have boundary links, and those echo our own root back.
    assign boundary_touch = ((COLUMN == 0) && west.fully_grown) ||
                            ((COLUMN == CODE_DISTANCE - 1) && east.fully_grown);

endmodule

`default_nettype wire

// File: src/grow_link.sv
`timescale 1ns/10ps
`default_nettype none

module grow_link #(
    parameter int WEIGHT = 2,
    parameter bit IS_BOUNDARY = 1'b0,
    localparam int CNT_WIDTH = $clog2(WEIGHT + 1)
) (
    input  wire                         clk,
    input  wire                         reset,
    input  wire decoder_pkg::stage_t    stage,
    input  wire decoder_pkg::addr_t     a_root,
    input  wire decoder_pkg::addr_t     b_root,
    input  wire                         a_odd,
    input  wire                         b_odd,
    output decoder_pkg::neighbor_t      to_a,
    output decoder_pkg::neighbor_t      to_b
);

    logic [CNT_WIDTH-1:0] count;
    logic [CNT_WIDTH:0]   sum;
    logic [1:0]           odd_count;
    logic                 fully_grown;

    // A boundary link has no b endpoint to grow from.
    assign odd_count = IS_BOUNDARY ? {1'b0, a_odd} : ({1'b0, a_odd} + {1'b0, b_odd});
    assign sum = {1'b0, count} + (CNT_WIDTH + 1)'(odd_count);

    always_ff @(posedge clk) begin
        if (reset || stage == decoder_pkg::stage_idle || stage == decoder_pkg::stage_loading) begin
            count <= '0;
        end else if (stage == decoder_pkg::stage_growing) begin
            if (sum >= (CNT_WIDTH + 1)'(WEIGHT)) begin
                count <= CNT_WIDTH'(WEIGHT);    // Saturate.
            end else begin
                count <= sum[CNT_WIDTH-1:0];
            end
        end
    end

    assign fully_grown = (count == CNT_WIDTH'(WEIGHT));

    generate
        if (IS_BOUNDARY) begin : boundary_g
            // Echoing a_root keeps the boundary from ever pulling the root.
            assign to_a = '{fully_grown: fully_grown, root: a_root};
            assign to_b = '{fully_grown: 1'b0, root: b_root};
        end else begin : interior_g
            assign to_a = '{fully_grown: fully_grown, root: b_root};
            assign to_b = '{fully_grown: fully_grown, root: a_root};
        end
    endgenerate

endmodule

`default_nettype wire

// File: src/decoder_pkg.sv
`default_nettype none

package decoder_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Addressing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Wide enough for the largest grid of 16 units.
    localparam int ADDR_WIDTH = 4;

    // Unit address is round * CODE_DISTANCE + column.
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decoder stages
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [2:0] {
        stage_idle      = 3'd0,
        stage_loading   = 3'd1,
        stage_merging   = 3'd2,
        stage_checking  = 3'd3,
        stage_growing   = 3'd4,
        stage_reporting = 3'd5
    } stage_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Link and output records
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // What a link tells one of its endpoint units.
    typedef struct packed {
        logic  fully_grown;
        addr_t root;         // Root of the unit on the far side.
    } neighbor_t;

    // One record per unit, sent in address order.
    typedef struct packed {
        addr_t address;
        addr_t root;
    } result_record_t;

endpackage

`default_nettype wire
